// ==== sim.f ====
nkmd_pkg.sv
nkmd_dcd_if.sv
nkmd_cpu_fetch.sv
nkmd_cpu_dcd.sv
nkmd_cpu_regfile.sv
nkmd_cpu_opnd.sv
nkmd_cpu_ex.sv
nkmd_cpu.sv
nkmd_cpu_sva.sv
tb_clk_gen.sv
nkmd_cpu_tb.sv

// ==== nkmd_cpu_tb.sv ====
`timescale 1ns/1ns

module nkmd_cpu_tb;

    localparam int RUN_CYCLES = 64;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (RUN_CYCLES + 4) + 60;
    localparam int PROG_WORDS = 128;
    localparam logic [31:0] R_KEY = 32'h5a5a_1234;
    localparam logic [31:0] C_OFS = 32'h0000_0100;

    logic clk;
    logic rst_init;
    logic rst_pulse = 1'b0;
    logic rst;
    nkmd_pkg::word_t p_addr, p_data, r_addr, r_data, c_addr, c_data, wb_val;
    nkmd_pkg::regsel_t wb_sel;

    nkmd_pkg::word_t prog [PROG_WORDS];
    nkmd_pkg::word_t ref_regs [16];
    nkmd_pkg::word_t exp_val [$], got_val [$], trace [$];
    nkmd_pkg::regsel_t exp_sel [$], got_sel [$];
    int first_wb = -1;
    int pp = 0;
    int errors = 0;
    int cycles = 0;
    logic [31:0] rng = 32'd89043;

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst_init));

    assign rst = rst_init | rst_pulse;

    // Combinational memory models
    assign p_data = (p_addr < PROG_WORDS) ? prog[p_addr] : '0;
    assign r_data = r_addr ^ R_KEY;
    assign c_data = c_addr + C_OFS;

    nkmd_cpu dut_i (
        .clk (clk), .rst (rst),
        .p_addr_o (p_addr), .p_data_i (p_data),
        .r_addr_o (r_addr), .r_data_i (r_data),
        .c_addr_o (c_addr), .c_data_i (c_data),
        .wb_sel_o (wb_sel), .wb_val_o (wb_val)
    );

    always @(posedge clk) begin
        if (!rst) begin
            trace.push_back(p_addr);
            if (wb_sel != '0) begin
                got_sel.push_back(wb_sel);
                got_val.push_back(wb_val);
                if (first_wb < 0) first_wb = trace.size() - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Low half of the next random word
    function automatic logic [15:0] rand_imm();
        logic [31:0] r;
        r = next_rand();
        return r[15:0];
    endfunction

    function automatic nkmd_pkg::word_t enc_imm(logic [3:0] rd, logic [3:0] rs, logic [15:0] v);
        return {4'b0, rd, 3'b0, rs, 1'b1, v};
    endfunction

    function automatic nkmd_pkg::word_t enc_reg(logic [3:0] rd, logic [2:0] op, logic [3:0] rs,
                                                logic [3:0] rt, logic rep, logic rr, logic cr);
        return {4'b0, rd, op, rs, 1'b0, 3'b0, rep, rt, 6'b0, rr, cr};
    endfunction

    function automatic nkmd_pkg::word_t enc_jmp(int off);
        nkmd_pkg::word_t w;
        w = 32'h8000_0000 | {24'b0, off[7:0]};
        if (off < 0) w[15] = 1'b1;
        return w;
    endfunction

    function automatic nkmd_pkg::word_t alu_ref(logic [2:0] op, nkmd_pkg::word_t s, nkmd_pkg::word_t t);
        case (op)
            3'd0: return s + t;
            3'd1: return s - t;
            3'd2: return s | t;
            3'd3: return s & t;
            3'd4: return s ^ t;
            default: return '0;
        endcase
    endfunction

    // Registers 0, ra and pc always read zero
    function automatic nkmd_pkg::word_t ref_read(logic [3:0] sel);
        if (sel == 4'd0 || sel == 4'd11 || sel == 4'd15) return '0;
        return ref_regs[sel];
    endfunction

    task automatic write_ref(logic [3:0] sel, nkmd_pkg::word_t val);
        if (sel != 4'd0) begin
            exp_sel.push_back(sel);
            exp_val.push_back(val);
        end
        if (sel != 4'd0 && sel != 4'd11 && sel != 4'd15) ref_regs[sel] = val;
    endtask

    // One instruction followed by two empty slots
    task automatic emit(nkmd_pkg::word_t inst);
        prog[pp] = inst;
        pp = pp + 3;
    endtask

    task automatic do_imm(logic [3:0] rd, logic [3:0] rs, logic [15:0] v);
        nkmd_pkg::word_t val;
        val = ref_read(rs) + {{16{v[15]}}, v};
        emit(enc_imm(rd, rs, v));
        write_ref(rd, val);
    endtask

    task automatic do_reg(logic [3:0] rd, logic [2:0] op, logic [3:0] rs, logic [3:0] rt,
                          logic rep, logic rr, logic cr);
        nkmd_pkg::word_t s, t, val;
        int count;
        s = rr ? (ref_read(rs) ^ R_KEY) : ref_read(rs);
        t = cr ? (ref_read(rt) + C_OFS) : ref_read(rt);
        val = alu_ref(op, s, t);
        count = 1;
        if (rep && ref_regs[14] > 1) count = ref_regs[14];
        emit(enc_reg(rd, op, rs, rt, rep, rr, cr));
        repeat (count) write_ref(rd, val);
        if (rep) ref_regs[14] = '0;
    endtask

    task automatic clear_prog();
        foreach (prog[i]) prog[i] = '0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        exp_sel.delete();
        exp_val.delete();
        pp = 0;
    endtask

    task automatic run_prog();
        @(posedge clk);
        rst_pulse <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        rst_pulse <= 1'b0;
        got_sel.delete();
        got_val.delete();
        trace.delete();
        first_wb = -1;
        repeat (RUN_CYCLES) @(posedge clk);
    endtask

    task automatic check_wb(string name);
        if (got_sel.size() != exp_sel.size()) begin
            $display("Error %0t: %s expected %0d writebacks, got %0d", $time, name,
                     exp_sel.size(), got_sel.size());
            errors++;
        end
        for (int i = 0; i < exp_sel.size() && i < got_sel.size(); i++) begin
            if (got_sel[i] != exp_sel[i] || got_val[i] !== exp_val[i]) begin
                $display("Error %0t: %s writeback %0d is r%0d=%h, expected r%0d=%h", $time,
                         name, i, got_sel[i], got_val[i], exp_sel[i], exp_val[i]);
                errors++;
            end
        end
    endtask

    task automatic test_imm();
        clear_prog();
        do_imm(4'd1, 4'd0, 16'h1234);
        do_imm(4'd2, 4'd0, 16'h8001);
        do_imm(4'd3, 4'd0, rand_imm());
        do_imm(4'd12, 4'd0, rand_imm());
        do_imm(4'd13, 4'd0, 16'hffff);
        do_imm(4'd14, 4'd0, rand_imm());
        run_prog();
        check_wb("imm");
        if (first_wb != 3) begin
            $display("Error %0t: first writeback in cycle %0d, expected 3", $time, first_wb);
            errors++;
        end
    endtask

    task automatic test_alu();
        clear_prog();
        do_imm(4'd1, 4'd0, rand_imm());
        do_imm(4'd2, 4'd0, rand_imm());
        for (int op = 0; op < 8; op++) begin
            do_reg(4'(3 + op), 3'(op), 4'd1, 4'd2, 1'b0, 1'b0, 1'b0);
        end
        do_reg(4'd11, 3'd0, 4'd1, 4'd2, 1'b0, 1'b0, 1'b0);
        do_reg(4'd15, 3'd2, 4'd1, 4'd2, 1'b0, 1'b0, 1'b0);
        do_reg(4'd12, 3'd2, 4'd11, 4'd15, 1'b0, 1'b0, 1'b0);
        run_prog();
        check_wb("alu");
    endtask

    task automatic test_bus();
        clear_prog();
        do_imm(4'd1, 4'd0, rand_imm());
        do_imm(4'd2, 4'd0, rand_imm());
        do_reg(4'd3, 3'd0, 4'd1, 4'd2, 1'b0, 1'b1, 1'b0);
        do_reg(4'd4, 3'd0, 4'd1, 4'd2, 1'b0, 1'b0, 1'b1);
        do_reg(4'd5, 3'd4, 4'd1, 4'd2, 1'b0, 1'b1, 1'b1);
        run_prog();
        check_wb("bus");
    endtask

    task automatic test_jump();
        nkmd_pkg::word_t exp_trace [15];
        clear_prog();
        exp_trace = '{0, 1, 2, 3, 4, 11, 12, 13, 14, 15, 6, 7, 8, 27, 28};
        prog[0] = enc_imm(4'd1, 4'd0, 16'd1);
        prog[3] = enc_jmp(8);
        prog[4] = enc_imm(4'd2, 4'd0, 16'd2);
        // Skipped slots
        prog[5] = enc_imm(4'd9, 4'd0, 16'd99);
        prog[16] = enc_imm(4'd10, 4'd0, 16'd98);
        prog[6] = enc_imm(4'd6, 4'd0, 16'd5);
        prog[7] = enc_jmp(20);
        prog[8] = enc_imm(4'd7, 4'd0, 16'd6);
        prog[11] = enc_imm(4'd3, 4'd0, 16'd3);
        prog[14] = enc_jmp(-8);
        prog[15] = enc_imm(4'd4, 4'd0, 16'd4);
        prog[27] = enc_imm(4'd8, 4'd0, 16'd7);
        write_ref(4'd1, 1);
        write_ref(4'd2, 2);
        write_ref(4'd3, 3);
        write_ref(4'd4, 4);
        write_ref(4'd6, 5);
        write_ref(4'd7, 6);
        write_ref(4'd8, 7);
        run_prog();
        check_wb("jump");
        foreach (exp_trace[i]) begin
            if (trace[i] !== exp_trace[i]) begin
                $display("Error %0t: jump p_addr_o in cycle %0d is %0d, expected %0d", $time,
                         i, trace[i], exp_trace[i]);
                errors++;
            end
        end
    endtask

    task automatic test_repeat();
        int n_vals [3];
        clear_prog();
        n_vals = '{0, 1, 4};
        do_imm(4'd1, 4'd0, rand_imm());
        do_imm(4'd2, 4'd0, rand_imm());
        foreach (n_vals[k]) begin
            do_imm(4'd14, 4'd0, n_vals[k][15:0]);
            do_reg(4'd3, 3'd0, 4'd1, 4'd2, 1'b1, 1'b0, 1'b0);
            do_reg(4'd4, 3'd0, 4'd14, 4'd0, 1'b0, 1'b0, 1'b0);
        end
        run_prog();
        check_wb("repeat");
    endtask

    initial begin
        wait (rst_init == 1'b0);
        test_imm();
        test_alu();
        test_bus();
        test_jump();
        test_repeat();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial clk_o = 1'b0;
    always #4 clk_o = ~clk_o;

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== nkmd_cpu_sva.sv ====
`timescale 1ns/1ns

module nkmd_cpu_sva (
    input logic              clk,
    input logic              rst,
    input nkmd_pkg::word_t   p_addr_i,
    input nkmd_pkg::regsel_t wb_sel_i,
    input nkmd_pkg::word_t   wb_val_i
);

    a_wb_idle_after_reset: assert property (@(posedge clk) rst |=> wb_sel_i == '0)
        else $error("wb_sel_o not zero after reset");

    a_pc_known: assert property (@(posedge clk) !rst |-> !$isunknown(p_addr_i))
        else $error("p_addr_o unknown");

    a_wb_val_known: assert property (@(posedge clk) disable iff (rst)
        wb_sel_i != '0 |-> !$isunknown(wb_val_i))
        else $error("wb_val_o unknown during writeback");

endmodule

bind nkmd_cpu nkmd_cpu_sva sva_i (
    .clk      (clk),
    .rst      (rst),
    .p_addr_i (p_addr_o),
    .wb_sel_i (wb_sel_o),
    .wb_val_i (wb_val_o)
);

// ==== nkmd_cpu.sv ====
`timescale 1ns/1ns

module nkmd_cpu (
    input  logic              clk,
    input  logic              rst,
    output nkmd_pkg::word_t   p_addr_o,
    input  nkmd_pkg::word_t   p_data_i,
    output nkmd_pkg::word_t   r_addr_o,
    input  nkmd_pkg::word_t   r_data_i,
    output nkmd_pkg::word_t   c_addr_o,
    input  nkmd_pkg::word_t   c_data_i,
    output nkmd_pkg::regsel_t wb_sel_o,
    output nkmd_pkg::word_t   wb_val_o
);

    logic              stall;
    logic              jmp_en;
    nkmd_pkg::word_t   jmp_pc;
    nkmd_pkg::word_t   pc;
    logic              regn_last;
    nkmd_pkg::word_t   rsval;
    nkmd_pkg::word_t   rtval;
    nkmd_pkg::word_t   sval;
    nkmd_pkg::word_t   tval;
    nkmd_pkg::alusel_t alusel;
    nkmd_pkg::regsel_t rdsel;
    nkmd_pkg::regsel_t wb_sel;
    nkmd_pkg::word_t   wb_val;

    nkmd_dcd_if dcd_bus ();

    nkmd_cpu_fetch fetch_i (
        .clk      (clk),
        .rst      (rst),
        .stall_i  (stall),
        .jmp_en_i (jmp_en),
        .jmp_pc_i (jmp_pc),
        .pc_o     (pc)
    );

    nkmd_cpu_dcd dcd_i (
        .clk         (clk),
        .rst         (rst),
        .inst_i      (p_data_i),
        .pc_i        (pc),
        .regn_last_i (regn_last),
        .dcd         (dcd_bus.dcd),
        .stall_o     (stall),
        .jmp_en_o    (jmp_en),
        .jmp_pc_o    (jmp_pc)
    );

    nkmd_cpu_regfile regfile_i (
        .clk         (clk),
        .rst         (rst),
        .dcd         (dcd_bus.rf),
        .wb_sel_i    (wb_sel),
        .wb_val_i    (wb_val),
        .rsval_o     (rsval),
        .rtval_o     (rtval),
        .regn_last_o (regn_last)
    );

    nkmd_cpu_opnd opnd_i (
        .clk      (clk),
        .rst      (rst),
        .dcd      (dcd_bus.opnd),
        .rsval_i  (rsval),
        .rtval_i  (rtval),
        .r_addr_o (r_addr_o),
        .r_data_i (r_data_i),
        .c_addr_o (c_addr_o),
        .c_data_i (c_data_i),
        .s_o      (sval),
        .t_o      (tval),
        .alusel_o (alusel),
        .rdsel_o  (rdsel)
    );

    nkmd_cpu_ex ex_i (
        .clk      (clk),
        .rst      (rst),
        .s_i      (sval),
        .t_i      (tval),
        .alusel_i (alusel),
        .rdsel_i  (rdsel),
        .wb_sel_o (wb_sel),
        .wb_val_o (wb_val)
    );

    // Writeback pair goes straight to the register file and the ports
    assign p_addr_o = pc;
    assign wb_sel_o = wb_sel;
    assign wb_val_o = wb_val;

endmodule

// ==== nkmd_cpu_ex.sv ====
`timescale 1ns/1ns

module nkmd_cpu_ex (
    input  logic              clk,
    input  logic              rst,
    input  nkmd_pkg::word_t   s_i,
    input  nkmd_pkg::word_t   t_i,
    input  nkmd_pkg::alusel_t alusel_i,
    input  nkmd_pkg::regsel_t rdsel_i,
    output nkmd_pkg::regsel_t wb_sel_o,
    output nkmd_pkg::word_t   wb_val_o
);

    nkmd_pkg::word_t   alu;
    nkmd_pkg::regsel_t wb_sel_q;
    nkmd_pkg::word_t   wb_val_q;

    always_comb begin
        case (alusel_i)
            nkmd_pkg::OP_ADD: alu = s_i + t_i;
            nkmd_pkg::OP_SUB: alu = s_i - t_i;
            nkmd_pkg::OP_OR: alu = s_i | t_i;
            nkmd_pkg::OP_AND: alu = s_i & t_i;
            nkmd_pkg::OP_XOR: alu = s_i ^ t_i;
            // Clamp and mul are not implemented
            nkmd_pkg::OP_RESERVED, nkmd_pkg::OP_CLAMP, nkmd_pkg::OP_MUL: alu = '0;
            default: alu = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_sel_q <= nkmd_pkg::REG_ZERO;
            wb_val_q <= '0;
        end else begin
            wb_sel_q <= rdsel_i;
            wb_val_q <= alu;
        end
    end

    assign wb_sel_o = wb_sel_q;
    assign wb_val_o = wb_val_q;

endmodule

// ==== nkmd_cpu_opnd.sv ====
`timescale 1ns/1ns

module nkmd_cpu_opnd (
    input  logic              clk,
    input  logic              rst,
    nkmd_dcd_if.opnd          dcd,
    input  nkmd_pkg::word_t   rsval_i,
    input  nkmd_pkg::word_t   rtval_i,
    output nkmd_pkg::word_t   r_addr_o,
    input  nkmd_pkg::word_t   r_data_i,
    output nkmd_pkg::word_t   c_addr_o,
    input  nkmd_pkg::word_t   c_data_i,
    output nkmd_pkg::word_t   s_o,
    output nkmd_pkg::word_t   t_o,
    output nkmd_pkg::alusel_t alusel_o,
    output nkmd_pkg::regsel_t rdsel_o
);

    nkmd_pkg::regsel_t rdsel_q;
    nkmd_pkg::alusel_t alusel_q;
    nkmd_pkg::word_t   imm_q;
    logic              immen_q;
    logic              r_read_q;
    logic              c_read_q;

    // One stage behind the decoder, level with the register read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdsel_q <= nkmd_pkg::REG_ZERO;
            alusel_q <= nkmd_pkg::OP_ADD;
            immen_q <= 1'b0;
            r_read_q <= 1'b0;
            c_read_q <= 1'b0;
        end else begin
            rdsel_q <= dcd.rdsel;
            alusel_q <= dcd.alusel;
            immen_q <= dcd.immen;
            r_read_q <= dcd.r_read_en;
            c_read_q <= dcd.c_read_en;
        end
    end

    always_ff @(posedge clk) begin
        imm_q <= dcd.imm;
    end

    assign r_addr_o = rsval_i;
    assign c_addr_o = rtval_i;

    assign s_o = r_read_q ? r_data_i : rsval_i;
    assign t_o = immen_q ? imm_q : (c_read_q ? c_data_i : rtval_i);
    assign alusel_o = immen_q ? nkmd_pkg::OP_ADD : alusel_q;
    assign rdsel_o = rdsel_q;

endmodule

// ==== nkmd_cpu_regfile.sv ====
`timescale 1ns/1ns

module nkmd_cpu_regfile (
    input  logic              clk,
    input  logic              rst,
    nkmd_dcd_if.rf            dcd,
    input  nkmd_pkg::regsel_t wb_sel_i,
    input  nkmd_pkg::word_t   wb_val_i,
    output nkmd_pkg::word_t   rsval_o,
    output nkmd_pkg::word_t   rtval_o,
    output logic              regn_last_o
);

    // a..j in slots 0..9, sl and sh in 10 and 11
    nkmd_pkg::word_t gpr_q [12];
    nkmd_pkg::word_t n_q;
    nkmd_pkg::word_t n_next;
    nkmd_pkg::word_t rsval_q;
    nkmd_pkg::word_t rtval_q;
    logic            regn_last_q;
    logic            gpr_we;

    function automatic logic [3:0] slot(input nkmd_pkg::regsel_t sel);
        if (sel > nkmd_pkg::REG_RA) begin
            slot = sel - 4'd2;
        end else begin
            slot = sel - 4'd1;
        end
    endfunction

    function automatic nkmd_pkg::word_t read_reg(input nkmd_pkg::regsel_t sel);
        case (sel)
            nkmd_pkg::REG_ZERO, nkmd_pkg::REG_RA, nkmd_pkg::REG_PC: read_reg = '0;
            nkmd_pkg::REG_N: read_reg = n_q;
            default: read_reg = gpr_q[slot(sel)];
        endcase
    endfunction

    always_ff @(posedge clk) begin
        rsval_q <= read_reg(dcd.rssel);
        rtval_q <= read_reg(dcd.rtsel);
    end

    // ra and pc writes are dropped, n has its own register
    assign gpr_we = (wb_sel_i != nkmd_pkg::REG_ZERO) && (wb_sel_i != nkmd_pkg::REG_RA) &&
                    (wb_sel_i != nkmd_pkg::REG_N) && (wb_sel_i != nkmd_pkg::REG_PC);

    always_ff @(posedge clk) begin
        if (gpr_we) begin
            gpr_q[slot(wb_sel_i)] <= wb_val_i;
        end
    end

    // Writeback to n beats the repeat decrement
    always_comb begin
        if (wb_sel_i == nkmd_pkg::REG_N) begin
            n_next = wb_val_i;
        end else if (dcd.repn && (n_q != '0)) begin
            n_next = n_q - 32'd1;
        end else begin
            n_next = n_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            n_q <= '0;
            regn_last_q <= 1'b1;
        end else begin
            n_q <= n_next;
            regn_last_q <= (n_next <= 32'd1);
        end
    end

    assign rsval_o = rsval_q;
    assign rtval_o = rtval_q;
    assign regn_last_o = regn_last_q;

endmodule

// ==== nkmd_cpu_dcd.sv ====
`timescale 1ns/1ns

module nkmd_cpu_dcd (
    input  logic            clk,
    input  logic            rst,
    input  nkmd_pkg::word_t inst_i,
    input  nkmd_pkg::word_t pc_i,
    input  logic            regn_last_i,
    nkmd_dcd_if.dcd         dcd,
    output logic            stall_o,
    output logic            jmp_en_o,
    output nkmd_pkg::word_t jmp_pc_o
);

    localparam int IMM_EXT = $bits(nkmd_pkg::word_t) - nkmd_pkg::IMM_W;
    localparam int JREL_EXT = $bits(nkmd_pkg::word_t) - nkmd_pkg::JREL_W;

    logic            jmp;
    logic            immen;
    logic            plain;
    logic            jmp_q;
    nkmd_pkg::word_t jmprel_q;
    nkmd_pkg::word_t pc_q;

    // Flag bits only count for register instructions
    assign jmp = inst_i[nkmd_pkg::BIT_JMP];
    assign immen = inst_i[nkmd_pkg::BIT_IMM];
    assign plain = !jmp && !immen;

    // Repeat sequencer
    assign stall_o = dcd.repn && !regn_last_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            dcd.rssel <= nkmd_pkg::REG_ZERO;
            dcd.rtsel <= nkmd_pkg::REG_ZERO;
            dcd.rdsel <= nkmd_pkg::REG_ZERO;
            dcd.alusel <= nkmd_pkg::OP_ADD;
            dcd.immen <= 1'b0;
            dcd.r_read_en <= 1'b0;
            dcd.c_read_en <= 1'b0;
            dcd.repn <= 1'b0;
            jmp_q <= 1'b0;
        end else if (!stall_o) begin
            dcd.rssel <= inst_i[nkmd_pkg::RS_LSB +: nkmd_pkg::REGSEL_W];
            dcd.rtsel <= inst_i[nkmd_pkg::RT_LSB +: nkmd_pkg::REGSEL_W];
            // Jumps never write back
            dcd.rdsel <= jmp ? nkmd_pkg::REG_ZERO : inst_i[nkmd_pkg::RD_LSB +: nkmd_pkg::REGSEL_W];
            dcd.alusel <= inst_i[nkmd_pkg::ALU_LSB +: nkmd_pkg::ALUSEL_W];
            dcd.immen <= immen;
            dcd.r_read_en <= plain && inst_i[nkmd_pkg::BIT_RREAD];
            dcd.c_read_en <= plain && inst_i[nkmd_pkg::BIT_CREAD];
            dcd.repn <= plain && inst_i[nkmd_pkg::BIT_REPN];
            jmp_q <= jmp;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            dcd.imm <= {{IMM_EXT{inst_i[nkmd_pkg::BIT_SIGN]}}, inst_i[nkmd_pkg::IMM_W-1:0]};
            jmprel_q <= {{JREL_EXT{inst_i[nkmd_pkg::BIT_SIGN]}}, inst_i[nkmd_pkg::JREL_W-1:0]};
            pc_q <= pc_i;
        end
    end

    // Target relative to the jump's own address
    assign jmp_en_o = jmp_q;
    assign jmp_pc_o = pc_q + jmprel_q;

endmodule

// ==== nkmd_cpu_fetch.sv ====
`timescale 1ns/1ns

module nkmd_cpu_fetch (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_i,
    input  logic            jmp_en_i,
    input  nkmd_pkg::word_t jmp_pc_i,
    output nkmd_pkg::word_t pc_o
);

    nkmd_pkg::word_t pc_q;

    // Jump wins over a repeat stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (jmp_en_i) begin
            pc_q <= jmp_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd1;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== nkmd_dcd_if.sv ====
`timescale 1ns/1ns

interface nkmd_dcd_if;

    nkmd_pkg::regsel_t rssel;
    nkmd_pkg::regsel_t rtsel;
    nkmd_pkg::regsel_t rdsel;
    nkmd_pkg::alusel_t alusel;
    nkmd_pkg::word_t imm;
    logic immen;
    logic r_read_en;
    logic c_read_en;
    logic repn;

    modport dcd (
        output rssel, rtsel, rdsel, alusel, imm, immen, r_read_en, c_read_en, repn
    );

    // Register read addresses plus the decrement strobe for n
    modport rf (input rssel, rtsel, repn);

    modport opnd (input rdsel, alusel, imm, immen, r_read_en, c_read_en);

endinterface

// ==== nkmd_pkg.sv ====
package nkmd_pkg;

    // Field widths
    localparam int REGSEL_W = 4;
    localparam int ALUSEL_W = 3;
    localparam int IMM_W = 15;
    localparam int JREL_W = 8;

    typedef logic [31:0] word_t;
    typedef logic [REGSEL_W-1:0] regsel_t;
    typedef logic [ALUSEL_W-1:0] alusel_t;

    // ALU operation codes
    localparam alusel_t OP_ADD = 3'd0;
    localparam alusel_t OP_SUB = 3'd1;
    localparam alusel_t OP_OR = 3'd2;
    localparam alusel_t OP_AND = 3'd3;
    localparam alusel_t OP_XOR = 3'd4;
    localparam alusel_t OP_RESERVED = 3'd5;
    localparam alusel_t OP_CLAMP = 3'd6;
    localparam alusel_t OP_MUL = 3'd7;

    // Register indices with special meaning
    localparam regsel_t REG_ZERO = 4'd0;
    localparam regsel_t REG_RA = 4'd11;
    localparam regsel_t REG_N = 4'd14;
    localparam regsel_t REG_PC = 4'd15;

    // Single bits of the instruction word
    localparam int BIT_JMP = 31;
    localparam int BIT_IMM = 16;
    localparam int BIT_SIGN = 15;
    localparam int BIT_REPN = 12;
    localparam int BIT_RREAD = 1;
    localparam int BIT_CREAD = 0;

    // Field positions
    localparam int RS_LSB = 17;
    localparam int RT_LSB = 8;
    localparam int RD_LSB = 24;
    localparam int ALU_LSB = 21;

endpackage
